// ==== lsu_top.f ====
src/gpu_cfg_pkg.sv
src/lsu_op_pkg.sv
src/lsu_decode.sv
src/lsu_execute.sv
src/lsu_dmem.sv
src/lsu_result.sv
src/lsu_top.sv
tb/lsu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the load/store unit testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module lsu_tb -f lsu_top.f -o lsu_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/lsu_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "STATUS: PASS" <<< "$sim_out"; then
	exit 0
fi

echo "simulation did not report a pass"
exit 1

// ==== tb/lsu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;
	import gpu_cfg_pkg::*;
	import lsu_op_pkg::*;

	localparam int num_threads = 4;
	localparam int nw_bits = 2;
	localparam int n_directed = 34;
	localparam int n_random = 200;
	localparam int timeout_cycles = 40 * (n_directed + n_random) + 200;

	logic clk;
	logic rst_n;
	logic [num_threads-1:0] req_valid;
	logic [num_threads-1:0][word_w-1:0] base_address;
	logic [word_w-1:0] offset;
	logic [num_threads-1:0][word_w-1:0] store_data;
	logic [mem_fn_w-1:0] mem_read;
	logic [mem_fn_w-1:0] mem_write;
	logic [reg_addr_w-1:0] rd;
	logic [nw_bits-1:0] warp_num;
	logic [wb_w-1:0] wb;
	logic [word_w-1:0] lsu_pc;
	logic no_slot_mem;
	logic out_delay;
	logic [num_threads-1:0] wb_valid;
	logic [reg_addr_w-1:0] wb_rd;
	logic [wb_w-1:0] wb_code;
	logic [nw_bits-1:0] wb_warp_num;
	logic [num_threads-1:0][word_w-1:0] loaded_data;
	logic [word_w-1:0] mem_wb_pc;

	integer seed = 32'h0c634891;
	int errors = 0;
	int loads_checked = 0;
	int cycle_count = 0;
	bit backpressure = 1'b0;

	logic [word_w-1:0] ref_mem [16]; // every test address falls in the low 16 words.
	logic [num_threads-1:0] exp_mask_q [$];
	logic [reg_addr_w-1:0] exp_rd_q [$];
	logic [nw_bits-1:0] exp_warp_q [$];
	logic [wb_w-1:0] exp_wb_q [$];
	logic [word_w-1:0] exp_pc_q [$];
	logic [num_threads-1:0][word_w-1:0] exp_data_q [$];

	lsu_top #(.num_threads(num_threads), .nw_bits(nw_bits), .mem_depth(256)) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// picks the addressed byte or half and extends it to a full word.
	function automatic logic [word_w-1:0] extend_load(input logic [word_w-1:0] word,
		input logic [1:0] size, input bit uns, input logic [1:0] sel);
		logic [7:0] b;
		logic [15:0] h;
		case (size)
			2'd0: begin
				b = word[8*sel +: 8];
				extend_load = uns ? {24'd0, b} : {{24{b[7]}}, b};
			end
			2'd1: begin
				h = word[8*sel +: 16];
				extend_load = uns ? {16'd0, h} : {{16{h[15]}}, h};
			end
			default: extend_load = word;
		endcase
	endfunction

	// odd threads get negative bytes and halves, even threads positive ones.
	function automatic logic [num_threads-1:0][word_w-1:0] rand_data();
		logic [word_w-1:0] r;
		for (int t = 0; t < num_threads; t++) begin
			r = $random(seed);
			rand_data[t] = (t % 2) ? (r | 32'h8080_8080) : (r & 32'h7f7f_7f7f);
		end
	endfunction

	function automatic logic [word_w-1:0] rand_addr(input logic [1:0] size);
		logic [word_w-1:0] a;
		a = 4 * ($unsigned($random(seed)) % 16);
		case (size)
			2'd0: a = a + $unsigned($random(seed)) % 4;
			2'd1: a = a + 2 * ($unsigned($random(seed)) % 2);
			default: a = a;
		endcase
		return a;
	endfunction

	task automatic check_value(input string what, input logic [word_w-1:0] got,
		input logic [word_w-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// drives one request at +2 ns and updates the model at the edge that takes it.
	task automatic issue(input bit store, input logic [mem_fn_w-1:0] fn,
		input logic [num_threads-1:0] mask, input logic [num_threads-1:0][word_w-1:0] addr,
		input logic [num_threads-1:0][word_w-1:0] data);
		logic [word_w-1:0] off;
		logic [num_threads-1:0][word_w-1:0] exp;
		logic [3:0] w;
		logic [1:0] sel;
		off = 4 * ($unsigned($random(seed)) % 8);
		exp = '0;
		req_valid = mask;
		offset = off;
		for (int t = 0; t < num_threads; t++) begin
			base_address[t] = addr[t] - off;
			store_data[t] = data[t];
		end
		mem_read = store ? mem_fn_none : fn;
		mem_write = store ? fn : mem_fn_none;
		rd = $random(seed);
		warp_num = $random(seed);
		wb = $random(seed);
		lsu_pc = $random(seed) & ~32'h3;
		while (out_delay) begin
			@(posedge clk);
			#2;
		end
		for (int t = 0; t < num_threads; t++) begin
			w = addr[t][5:2];
			sel = addr[t][1:0];
			if (mask[t] && store) begin
				case (fn[1:0]) // low two code bits give the size, bit 2 the zero extension.
					2'd0: ref_mem[w][8*sel +: 8] = data[t][7:0];
					2'd1: ref_mem[w][8*sel +: 16] = data[t][15:0];
					default: ref_mem[w] = data[t];
				endcase
			end else if (mask[t]) begin
				exp[t] = extend_load(ref_mem[w], fn[1:0], fn[2], sel);
			end
		end
		if (!store) begin
			exp_mask_q.push_back(mask);
			exp_rd_q.push_back(rd);
			exp_warp_q.push_back(warp_num);
			exp_wb_q.push_back(wb);
			exp_pc_q.push_back(lsu_pc);
			exp_data_q.push_back(exp);
		end
		@(posedge clk);
		#2;
		req_valid = '0;
		mem_read = mem_fn_none;
		mem_write = mem_fn_none;
	endtask

	always @(posedge clk) begin
		#1 no_slot_mem = backpressure && ($unsigned($random(seed)) % 3 == 0);
	end

	// a writeback is consumed at each edge where the core has a slot for it.
	always @(posedge clk) begin
		if (rst_n && (|wb_valid) && !no_slot_mem) begin
			if (exp_mask_q.size() == 0) begin
				errors++;
				$display("writeback at %0d ns arrived while no load was outstanding", $time);
			end else begin
				check_value("wb_valid", wb_valid, exp_mask_q[0]);
				check_value("wb_rd", wb_rd, exp_rd_q[0]);
				check_value("wb_warp_num", wb_warp_num, exp_warp_q[0]);
				check_value("wb_code", wb_code, exp_wb_q[0]);
				check_value("mem_wb_pc", mem_wb_pc, exp_pc_q[0]);
				for (int t = 0; t < num_threads; t++) begin
					if (exp_mask_q[0][t]) begin
						check_value($sformatf("loaded_data[%0d]", t), loaded_data[t],
							exp_data_q[0][t]);
					end
				end
				loads_checked++;
				void'(exp_mask_q.pop_front());
				void'(exp_rd_q.pop_front());
				void'(exp_warp_q.pop_front());
				void'(exp_wb_q.pop_front());
				void'(exp_pc_q.pop_front());
				void'(exp_data_q.pop_front());
			end
		end
	end

	initial begin
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, %0d loads never written back", cycle_count,
			exp_mask_q.size());
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		logic [num_threads-1:0][word_w-1:0] a;
		logic [num_threads-1:0] m;
		logic [mem_fn_w-1:0] fn;
		bit st;
		rst_n = 1'b0;
		req_valid = '0;
		base_address = '0;
		offset = '0;
		store_data = '0;
		mem_read = mem_fn_none;
		mem_write = mem_fn_none;
		rd = '0;
		warp_num = '0;
		wb = '0;
		lsu_pc = '0;
		no_slot_mem = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_value("out_delay after reset", out_delay, '0);
		check_value("wb_valid after reset", wb_valid, '0);

		// fill all 16 words, then read them back with the thread order reversed.
		for (int k = 0; k < 4; k++) begin
			for (int t = 0; t < num_threads; t++) begin
				a[t] = 4 * (4 * k + t);
			end
			issue(1'b1, st_word, '1, a, rand_data());
		end
		for (int k = 0; k < 4; k++) begin
			for (int t = 0; t < num_threads; t++) begin
				a[t] = 4 * (4 * (3 - k) + 3 - t);
			end
			issue(1'b0, ld_word, '1, a, '0);
		end

		// bytes into every lane of words 0 to 3, halves into words 4 to 7.
		for (int o = 0; o < 4; o++) begin
			for (int t = 0; t < num_threads; t++) begin
				a[t] = 4 * t + o;
			end
			issue(1'b1, st_byte, '1, a, rand_data());
		end
		for (int o = 0; o < 4; o += 2) begin
			for (int t = 0; t < num_threads; t++) begin
				a[t] = 4 * (t + 4) + o;
			end
			issue(1'b1, st_half, '1, a, rand_data());
		end
		for (int o = 0; o < 4; o++) begin
			for (int t = 0; t < num_threads; t++) begin
				a[t] = 4 * t + o;
			end
			issue(1'b0, ld_byte, '1, a, '0);
			issue(1'b0, ld_byte_u, '1, a, '0);
			if (o % 2 == 0) begin
				for (int t = 0; t < num_threads; t++) begin
					a[t] = 4 * (t + 4) + o;
				end
				issue(1'b0, ld_half, '1, a, '0);
				issue(1'b0, ld_half_u, '1, a, '0);
			end
		end

		// partial masks on words 8 to 11.
		for (int t = 0; t < num_threads; t++) begin
			a[t] = 4 * (t + 8);
		end
		issue(1'b1, st_word, 4'b0101, a, rand_data());
		issue(1'b0, ld_word, '1, a, '0);
		issue(1'b0, ld_word, 4'b1010, a, '0);
		issue(1'b0, ld_half_u, 4'b1000, a, '0);

		// every thread on one word, so thread 3 must win.
		for (int t = 0; t < num_threads; t++) begin
			a[t] = 4 * 12;
		end
		issue(1'b1, st_word, '1, a, rand_data());
		issue(1'b0, ld_word, '1, a, '0);
		for (int t = 0; t < num_threads; t++) begin
			a[t] = 4 * 13 + 1;
		end
		issue(1'b1, st_byte, 4'b0111, a, rand_data());
		for (int t = 0; t < num_threads; t++) begin
			a[t] = 4 * 13;
		end
		issue(1'b0, ld_word, 4'b0001, a, '0);

		backpressure = 1'b1;
		for (int n = 0; n < n_random; n++) begin
			st = ($random(seed) & 1) != 0;
			fn = st ? $unsigned($random(seed)) % 3 : $unsigned($random(seed)) % 6;
			if (fn == 3'd3) begin
				fn = ld_word; // code 3 is unused on the load side.
			end
			m = $random(seed);
			if (m == '0) begin
				m = 4'b0001;
			end
			for (int t = 0; t < num_threads; t++) begin
				a[t] = rand_addr(fn[1:0]);
			end
			issue(st, fn, m, a, rand_data());
		end
		backpressure = 1'b0;

		while (exp_mask_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk); // a duplicate writeback would still show up here.
		$display("lsu_tb done: %0d loads checked, %0d errors", loads_checked, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/lsu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
	parameter int num_threads = 4,
	parameter int nw_bits = 2,
	parameter int mem_depth = 256
) (
	input logic clk,
	input logic rst_n,
	input logic [num_threads-1:0] req_valid,
	input logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] base_address,
	input logic [gpu_cfg_pkg::word_w-1:0] offset,
	input logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] store_data,
	input logic [lsu_op_pkg::mem_fn_w-1:0] mem_read,
	input logic [lsu_op_pkg::mem_fn_w-1:0] mem_write,
	input logic [gpu_cfg_pkg::reg_addr_w-1:0] rd,
	input logic [nw_bits-1:0] warp_num,
	input logic [gpu_cfg_pkg::wb_w-1:0] wb,
	input logic [gpu_cfg_pkg::word_w-1:0] lsu_pc,
	input logic no_slot_mem,
	output logic out_delay,
	output logic [num_threads-1:0] wb_valid,
	output logic [gpu_cfg_pkg::reg_addr_w-1:0] wb_rd,
	output logic [gpu_cfg_pkg::wb_w-1:0] wb_code,
	output logic [nw_bits-1:0] wb_warp_num,
	output logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] loaded_data,
	output logic [gpu_cfg_pkg::word_w-1:0] mem_wb_pc
);
	import gpu_cfg_pkg::*;
	import lsu_op_pkg::*;

	logic [num_threads-1:0][word_w-1:0] address;
	logic is_load;
	logic is_store;
	size_e size;
	logic is_unsigned;

	logic [num_threads-1:0] use_valid;
	logic [num_threads-1:0][word_w-1:0] use_address;
	logic [num_threads-1:0][word_w-1:0] use_store_data;
	logic use_is_load;
	logic use_is_store;
	size_e use_size;
	logic use_is_unsigned;
	logic [reg_addr_w-1:0] use_rd;
	logic [nw_bits-1:0] use_warp_num;
	logic [wb_w-1:0] use_wb;
	logic [word_w-1:0] use_pc;

	logic [num_threads-1:0] rsp_valid;
	logic [reg_addr_w-1:0] rsp_rd;
	logic [wb_w-1:0] rsp_wb;
	logic [nw_bits-1:0] rsp_warp_num;
	logic [num_threads-1:0][word_w-1:0] rsp_pc;
	logic [num_threads-1:0][word_w-1:0] rsp_word;
	size_e rsp_size;
	logic rsp_unsigned;
	logic [num_threads-1:0][1:0] rsp_byte_sel;

	lsu_decode #(.num_threads(num_threads)) i_decode (
		.base_address (base_address),
		.offset       (offset),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.address      (address),
		.is_load      (is_load),
		.is_store     (is_store),
		.size         (size),
		.is_unsigned  (is_unsigned)
	);

	lsu_execute #(.num_threads(num_threads), .nw_bits(nw_bits)) i_execute (
		.clk             (clk),
		.rst_n           (rst_n),
		.delay_req       (out_delay),
		.req_valid       (req_valid),
		.address         (address),
		.store_data      (store_data),
		.is_load         (is_load),
		.is_store        (is_store),
		.size            (size),
		.is_unsigned     (is_unsigned),
		.rd              (rd),
		.warp_num        (warp_num),
		.wb              (wb),
		.lsu_pc          (lsu_pc),
		.use_valid       (use_valid),
		.use_address     (use_address),
		.use_store_data  (use_store_data),
		.use_is_load     (use_is_load),
		.use_is_store    (use_is_store),
		.use_size        (use_size),
		.use_is_unsigned (use_is_unsigned),
		.use_rd          (use_rd),
		.use_warp_num    (use_warp_num),
		.use_wb          (use_wb),
		.use_pc          (use_pc)
	);

	// the memory's delay level is the stall seen by the core.
	lsu_dmem #(
		.num_threads (num_threads),
		.nw_bits     (nw_bits),
		.mem_depth   (mem_depth)
	) i_dmem (
		.clk             (clk),
		.rst_n           (rst_n),
		.no_slot_mem     (no_slot_mem),
		.use_valid       (use_valid),
		.use_address     (use_address),
		.use_store_data  (use_store_data),
		.use_is_load     (use_is_load),
		.use_is_store    (use_is_store),
		.use_size        (use_size),
		.use_is_unsigned (use_is_unsigned),
		.use_rd          (use_rd),
		.use_warp_num    (use_warp_num),
		.use_wb          (use_wb),
		.use_pc          (use_pc),
		.delay_req       (out_delay),
		.rsp_valid       (rsp_valid),
		.rsp_rd          (rsp_rd),
		.rsp_wb          (rsp_wb),
		.rsp_warp_num    (rsp_warp_num),
		.rsp_pc          (rsp_pc),
		.rsp_word        (rsp_word),
		.rsp_size        (rsp_size),
		.rsp_unsigned    (rsp_unsigned),
		.rsp_byte_sel    (rsp_byte_sel)
	);

	lsu_result #(.num_threads(num_threads), .nw_bits(nw_bits)) i_result (
		.rsp_valid    (rsp_valid),
		.rsp_rd       (rsp_rd),
		.rsp_wb       (rsp_wb),
		.rsp_warp_num (rsp_warp_num),
		.rsp_pc       (rsp_pc),
		.rsp_word     (rsp_word),
		.rsp_size     (rsp_size),
		.rsp_unsigned (rsp_unsigned),
		.rsp_byte_sel (rsp_byte_sel),
		.wb_valid     (wb_valid),
		.wb_rd        (wb_rd),
		.wb_code      (wb_code),
		.wb_warp_num  (wb_warp_num),
		.loaded_data  (loaded_data),
		.mem_wb_pc    (mem_wb_pc)
	);

endmodule

`default_nettype wire

// ==== src/lsu_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_result #(
	parameter int num_threads = 4,
	parameter int nw_bits = 2
) (
	input logic [num_threads-1:0] rsp_valid,
	input logic [gpu_cfg_pkg::reg_addr_w-1:0] rsp_rd,
	input logic [gpu_cfg_pkg::wb_w-1:0] rsp_wb,
	input logic [nw_bits-1:0] rsp_warp_num,
	input logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] rsp_pc,
	input logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] rsp_word,
	input lsu_op_pkg::size_e rsp_size,
	input logic rsp_unsigned,
	input logic [num_threads-1:0][1:0] rsp_byte_sel,
	output logic [num_threads-1:0] wb_valid,
	output logic [gpu_cfg_pkg::reg_addr_w-1:0] wb_rd,
	output logic [gpu_cfg_pkg::wb_w-1:0] wb_code,
	output logic [nw_bits-1:0] wb_warp_num,
	output logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] loaded_data,
	output logic [gpu_cfg_pkg::word_w-1:0] mem_wb_pc
);
	import gpu_cfg_pkg::*;
	import lsu_op_pkg::*;

	localparam int idx_w = (num_threads > 1) ? $clog2(num_threads) : 1;

	logic [idx_w-1:0] pc_idx;
	logic found;

	assign wb_valid = rsp_valid;
	assign wb_rd = rsp_rd;
	assign wb_code = rsp_wb;
	assign wb_warp_num = rsp_warp_num;

	always_comb begin
		logic [word_w-1:0] shifted;
		for (int t = 0; t < num_threads; t++) begin
			shifted = rsp_word[t] >> {rsp_byte_sel[t], 3'b000}; // addressed lane to bit 0.
			case (rsp_size)
				size_byte: loaded_data[t] = rsp_unsigned ? word_w'(shifted[7:0])
					: {{(word_w-8){shifted[7]}}, shifted[7:0]};
				size_half: loaded_data[t] = rsp_unsigned ? word_w'(shifted[15:0])
					: {{(word_w-16){shifted[15]}}, shifted[15:0]};
				default: loaded_data[t] = rsp_word[t];
			endcase
		end
	end

	// lowest valid thread wins.
	always_comb begin
		pc_idx = '0;
		found = 1'b0;
		for (int t = num_threads - 1; t >= 0; t--) begin
			if (rsp_valid[t]) begin
				pc_idx = idx_w'(t);
				found = 1'b1;
			end
		end
	end

	assign mem_wb_pc = found ? rsp_pc[pc_idx] : '0;

	// every valid thread of one warp carries the same pc.
	always_comb begin
		for (int t = 0; t < num_threads; t++) begin
			if (rsp_valid[t]) begin
				a_same_pc: assert (rsp_pc[t] == rsp_pc[pc_idx])
					else $error("thread %0d pc differs from the writeback pc", t);
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/lsu_dmem.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_dmem #(
	parameter int num_threads = 4,
	parameter int nw_bits = 2,
	parameter int mem_depth = 256
) (
	input logic clk,
	input logic rst_n,
	input logic no_slot_mem,
	input logic [num_threads-1:0] use_valid,
	input logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] use_address,
	input logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] use_store_data,
	input logic use_is_load,
	input logic use_is_store,
	input lsu_op_pkg::size_e use_size,
	input logic use_is_unsigned,
	input logic [gpu_cfg_pkg::reg_addr_w-1:0] use_rd,
	input logic [nw_bits-1:0] use_warp_num,
	input logic [gpu_cfg_pkg::wb_w-1:0] use_wb,
	input logic [gpu_cfg_pkg::word_w-1:0] use_pc,
	output logic delay_req,
	output logic [num_threads-1:0] rsp_valid,
	output logic [gpu_cfg_pkg::reg_addr_w-1:0] rsp_rd,
	output logic [gpu_cfg_pkg::wb_w-1:0] rsp_wb,
	output logic [nw_bits-1:0] rsp_warp_num,
	output logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] rsp_pc,
	output logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] rsp_word,
	output lsu_op_pkg::size_e rsp_size,
	output logic rsp_unsigned,
	output logic [num_threads-1:0][1:0] rsp_byte_sel
);
	import gpu_cfg_pkg::*;
	import lsu_op_pkg::*;

	localparam int idx_w = (mem_depth > 1) ? $clog2(mem_depth) : 1;
	localparam int lanes = word_w / 8;

	logic [word_w-1:0] mem [mem_depth];
	logic [num_threads-1:0][idx_w-1:0] word_idx;
	logic [num_threads-1:0][lanes-1:0] byte_en;
	logic [num_threads-1:0][word_w-1:0] wdata;
	logic [num_threads-1:0] misaligned;
	logic advance;

	// the core has no slot for the held load, so nothing moves.
	assign delay_req = (|rsp_valid) && no_slot_mem;
	assign advance = !delay_req;

	always_comb begin
		for (int t = 0; t < num_threads; t++) begin
			word_idx[t] = idx_w'(use_address[t][word_w-1:2] % mem_depth);
			wdata[t] = use_store_data[t] << {use_address[t][1:0], 3'b000};
			case (use_size)
				size_byte: begin
					byte_en[t] = lanes'(1) << use_address[t][1:0];
					misaligned[t] = 1'b0;
				end
				size_half: begin
					byte_en[t] = lanes'(3) << use_address[t][1:0];
					misaligned[t] = use_address[t][0];
				end
				default: begin
					byte_en[t] = '1;
					misaligned[t] = |use_address[t][1:0];
				end
			endcase
		end
	end

	// ascending thread order lets the highest thread win a shared word.
	always_ff @(posedge clk) begin
		if (rst_n && advance && use_is_store) begin
			for (int t = 0; t < num_threads; t++) begin
				for (int b = 0; b < lanes; b++) begin
					if (use_valid[t] && byte_en[t][b]) begin
						mem[word_idx[t]][8*b +: 8] <= wdata[t][8*b +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rsp_valid <= '0;
		end else if (advance) begin
			rsp_valid <= use_is_load ? use_valid : '0; // stores give no writeback.
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			rsp_rd <= use_rd;
			rsp_wb <= use_wb;
			rsp_warp_num <= use_warp_num;
			rsp_size <= use_size;
			rsp_unsigned <= use_is_unsigned;
			for (int t = 0; t < num_threads; t++) begin
				rsp_word[t] <= mem[word_idx[t]];
				rsp_pc[t] <= use_pc;
				rsp_byte_sel[t] <= use_address[t][1:0];
			end
		end
	end

	for (genvar t = 0; t < num_threads; t++) begin : g_align
		a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
			use_valid[t] && (use_is_load || use_is_store) |-> !misaligned[t]);
	end

endmodule

`default_nettype wire

// ==== src/lsu_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_execute #(
	parameter int num_threads = 4,
	parameter int nw_bits = 2
) (
	input logic clk,
	input logic rst_n,
	input logic delay_req,
	input logic [num_threads-1:0] req_valid,
	input logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] address,
	input logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] store_data,
	input logic is_load,
	input logic is_store,
	input lsu_op_pkg::size_e size,
	input logic is_unsigned,
	input logic [gpu_cfg_pkg::reg_addr_w-1:0] rd,
	input logic [nw_bits-1:0] warp_num,
	input logic [gpu_cfg_pkg::wb_w-1:0] wb,
	input logic [gpu_cfg_pkg::word_w-1:0] lsu_pc,
	output logic [num_threads-1:0] use_valid,
	output logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] use_address,
	output logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] use_store_data,
	output logic use_is_load,
	output logic use_is_store,
	output lsu_op_pkg::size_e use_size,
	output logic use_is_unsigned,
	output logic [gpu_cfg_pkg::reg_addr_w-1:0] use_rd,
	output logic [nw_bits-1:0] use_warp_num,
	output logic [gpu_cfg_pkg::wb_w-1:0] use_wb,
	output logic [gpu_cfg_pkg::word_w-1:0] use_pc
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			use_valid <= '0;
		end else if (!delay_req) begin
			use_valid <= req_valid; // an empty mask simply drains the buffer.
		end
	end

	always_ff @(posedge clk) begin
		if (!delay_req) begin
			use_address <= address;
			use_store_data <= store_data;
			use_is_load <= is_load;
			use_is_store <= is_store;
			use_size <= size;
			use_is_unsigned <= is_unsigned;
			use_rd <= rd;
			use_warp_num <= warp_num;
			use_wb <= wb;
			use_pc <= lsu_pc;
		end
	end

	// a stalled request stays on the inputs until the buffer takes it.
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		delay_req && (|req_valid) |=> $stable(req_valid) && $stable(address)
			&& $stable(store_data));

endmodule

`default_nettype wire

// ==== src/lsu_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_decode #(
	parameter int num_threads = 4
) (
	input logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] base_address,
	input logic [gpu_cfg_pkg::word_w-1:0] offset,
	input logic [lsu_op_pkg::mem_fn_w-1:0] mem_read,
	input logic [lsu_op_pkg::mem_fn_w-1:0] mem_write,
	output logic [num_threads-1:0][gpu_cfg_pkg::word_w-1:0] address,
	output logic is_load,
	output logic is_store,
	output lsu_op_pkg::size_e size,
	output logic is_unsigned
);
	import lsu_op_pkg::*;

	lsu_op_t rd_op;
	lsu_op_t wr_op;

	assign rd_op = mem_read;
	assign wr_op = mem_write;

	assign is_load = (rd_op.ld != ld_none);
	assign is_store = (wr_op.st != st_none);

	always_comb begin
		for (int t = 0; t < num_threads; t++) begin
			address[t] = base_address[t] + offset; // shared immediate offset.
		end
	end

	always_comb begin
		size = size_word;
		is_unsigned = 1'b0;
		if (is_load) begin
			is_unsigned = rd_op.ld inside {ld_byte_u, ld_half_u};
			case (rd_op.ld)
				ld_byte, ld_byte_u: size = size_byte;
				ld_half, ld_half_u: size = size_half;
				default: size = size_word;
			endcase
		end else if (is_store) begin
			case (wr_op.st)
				st_byte: size = size_byte;
				st_half: size = size_half;
				default: size = size_word;
			endcase
		end
	end

	// an instruction is either a load or a store, never both.
	always_comb begin
		a_one_side: assert (!(is_load && is_store))
			else $error("mem_read and mem_write both active");
	end

endmodule

`default_nettype wire

// ==== src/lsu_op_pkg.sv ====
`default_nettype none

package lsu_op_pkg;

	localparam int mem_fn_w = 3;
	localparam logic [mem_fn_w-1:0] mem_fn_none = 3'd7; // no access on this side.

	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} size_e;

	// load side. the top bit asks for zero extension.
	typedef enum logic [mem_fn_w-1:0] {
		ld_byte = 3'd0,
		ld_half = 3'd1,
		ld_word = 3'd2,
		ld_byte_u = 3'd4,
		ld_half_u = 3'd5,
		ld_none = mem_fn_none
	} load_fn_e;

	// store side. the top bit carries no meaning here.
	typedef enum logic [mem_fn_w-1:0] {
		st_byte = 3'd0,
		st_half = 3'd1,
		st_word = 3'd2,
		st_none = mem_fn_none
	} store_fn_e;

	// one function code, seen as a load or as a store.
	typedef union packed {
		load_fn_e ld;
		store_fn_e st;
	} lsu_op_t;

endpackage

`default_nettype wire

// ==== src/gpu_cfg_pkg.sv ====
`default_nettype none

package gpu_cfg_pkg;

	localparam int word_w = 32; // one data word, also the address width.
	localparam int reg_addr_w = 5;
	localparam int wb_w = 2;

	// writeback source selected at commit.
	localparam logic [wb_w-1:0] wb_none = 2'd0;
	localparam logic [wb_w-1:0] wb_alu = 2'd1;
	localparam logic [wb_w-1:0] wb_mem = 2'd2; // only this one comes back from the load unit.
	localparam logic [wb_w-1:0] wb_jal = 2'd3;

endpackage

`default_nettype wire
